// ==== common/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_bits = 5;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // major opcodes, instr[6:2]
  localparam logic [4:0] opc_load   = 5'b00000;
  localparam logic [4:0] opc_store  = 5'b01000;
  localparam logic [4:0] opc_branch = 5'b11000;
  localparam logic [4:0] opc_jal    = 5'b11011;
  localparam logic [4:0] opc_jalr   = 5'b11001;
  localparam logic [4:0] opc_op_imm = 5'b00100;
  localparam logic [4:0] opc_op     = 5'b01100;
  localparam logic [4:0] opc_lui    = 5'b01101;
  localparam logic [4:0] opc_auipc  = 5'b00101;
  localparam logic [4:0] opc_system = 5'b11100;

  // immediate forms share these, use_imm tells them apart
  typedef enum logic [4:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_lw,
    op_sw,
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_halt,
    op_illegal
  } op_e;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
module reg_file import rv_pkg::*; (
  input  var logic                     clk,
  input  var logic                     reset,
  input  var logic [reg_addr_bits-1:0] rs1,
  input  var logic [reg_addr_bits-1:0] rs2,
  output var logic [xlen-1:0]          reg_rs1,
  output var logic [xlen-1:0]          reg_rs2,
  input  var logic                     wb_enable,
  input  var logic [reg_addr_bits-1:0] wb_rd,
  input  var logic [xlen-1:0]          wb_value
);

  logic [xlen-1:0] regs [2**reg_addr_bits];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_bits; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_enable && wb_rd != '0) begin
      regs[wb_rd] <= wb_value;
    end
  end

  // x0 is hardwired
  assign reg_rs1 = (rs1 == '0) ? '0 : regs[rs1];
  assign reg_rs2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
module mem_arbiter import rv_pkg::*; (
  input  var logic            clk,
  input  var logic            reset,
  // fetcher requester
  input  var logic            fetch_valid,
  output var logic            fetch_ready,
  input  var logic [xlen-1:0] fetch_addr,
  output var logic            fetch_rvalid,
  output var logic [xlen-1:0] fetch_rdata,
  // executor requester
  input  var logic            data_valid,
  output var logic            data_ready,
  input  var logic [xlen-1:0] data_addr,
  input  var logic            data_write,
  input  var logic [xlen-1:0] data_wdata,
  output var logic            data_rvalid,
  output var logic [xlen-1:0] data_rdata,
  // shared memory bus
  output var logic            mem_valid,
  input  var logic            mem_ready,
  output var logic [xlen-1:0] mem_addr,
  output var logic            mem_write,
  output var logic [xlen-1:0] mem_wdata,
  input  var logic            mem_rvalid,
  input  var logic [xlen-1:0] mem_rdata
);

  typedef enum logic [1:0] {own_none, own_fetch, own_data} owner_e;

  owner_e owner;
  logic idle;
  logic sel_data;
  logic req_pending, pending_data;

  assign idle = owner == own_none;
  // a request stalled by mem_ready keeps its selection
  assign sel_data = req_pending ? pending_data : data_valid;

  assign mem_valid = idle && (sel_data ? data_valid : fetch_valid);
  assign mem_addr = sel_data ? data_addr : fetch_addr;
  assign mem_write = sel_data && data_write;
  assign mem_wdata = data_wdata;
  assign fetch_ready = idle && mem_ready && !sel_data;
  assign data_ready = idle && mem_ready && sel_data;

  assign fetch_rvalid = mem_rvalid && owner == own_fetch;
  assign data_rvalid = mem_rvalid && owner == own_data;
  assign fetch_rdata = mem_rdata;
  assign data_rdata = mem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= own_none;
      req_pending <= 1'b0;
    end else begin
      req_pending <= mem_valid && !mem_ready;
      if (mem_valid && mem_ready) begin
        owner <= sel_data ? own_data : own_fetch;
      end else if (mem_rvalid) begin
        owner <= own_none;
      end
    end
  end

  always_ff @(posedge clk) begin
    pending_data <= sel_data;
  end

  // every response goes to exactly one granted requester
  single_response: assert property (@(posedge clk) disable iff (reset)
    mem_rvalid |-> fetch_rvalid ^ data_rvalid);

endmodule

// ==== fetch/fetcher.sv ====
`timescale 1ns/1ps
module fetcher import rv_pkg::*; (
  input  var logic            clk,
  input  var logic            reset,
  // retire path from the executor
  input  var logic            retire,
  input  var logic [xlen-1:0] next_pc,
  // bus side
  output var logic            fetch_valid,
  input  var logic            fetch_ready,
  output var logic [xlen-1:0] fetch_addr,
  input  var logic            fetch_rvalid,
  input  var logic [xlen-1:0] fetch_rdata,
  // decoder side
  output var logic            instr_valid,
  input  var logic            instr_ready,
  output var logic [xlen-1:0] instr,
  output var logic [xlen-1:0] instr_pc
);

  typedef enum logic [1:0] {st_request, st_wait, st_hold} state_e;

  state_e state;
  logic [xlen-1:0] pc;

  assign fetch_addr = pc;
  assign instr_pc = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_request;
      fetch_valid <= 1'b0;
      instr_valid <= 1'b0;
      pc <= reset_pc;
    end else begin
      case (state)
        st_request: begin
          // first cycle out of reset raises the request
          fetch_valid <= 1'b1;
          if (fetch_valid && fetch_ready) begin
            fetch_valid <= 1'b0;
            state <= st_wait;
          end
        end
        st_wait: begin
          if (fetch_rvalid) begin
            instr_valid <= 1'b1;
            state <= st_hold;
          end
        end
        default: begin
          if (instr_valid && instr_ready) begin
            instr_valid <= 1'b0;
          end
          // next word only once the previous instruction is done
          if (retire) begin
            pc <= next_pc;
            fetch_valid <= 1'b1;
            state <= st_request;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_wait && fetch_rvalid) begin
      instr <= fetch_rdata;
    end
  end

endmodule

// ==== decode/decoder.sv ====
`timescale 1ns/1ps
module decoder import rv_pkg::*; (
  input  var logic                     clk,
  input  var logic                     reset,
  // from the fetcher
  input  var logic                     instr_valid,
  output var logic                     instr_ready,
  input  var logic [xlen-1:0]          instr,
  input  var logic [xlen-1:0]          instr_pc,
  // register file reads
  output var logic [reg_addr_bits-1:0] rs1,
  output var logic [reg_addr_bits-1:0] rs2,
  input  var logic [xlen-1:0]          reg_rs1,
  input  var logic [xlen-1:0]          reg_rs2,
  // to the executor
  output var logic                     dec_valid,
  input  var logic                     exec_ready,
  output var op_e                      op,
  output var logic                     use_imm,
  output var logic [xlen-1:0]          immediate,
  output var logic [reg_addr_bits-1:0] rd,
  output var logic [xlen-1:0]          rs1_value,
  output var logic [xlen-1:0]          rs2_value,
  output var logic [xlen-1:0]          pc
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  op_e dec_op;
  logic dec_use_imm;
  logic [xlen-1:0] dec_imm;
  logic accept;

  assign opcode = instr[6:2];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec_op = op_illegal;
    dec_use_imm = 1'b0;
    dec_imm = imm_i;
    // compressed encodings fall through as illegal
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        opc_lui: begin
          dec_op = op_lui;
          dec_imm = imm_u;
        end
        opc_auipc: begin
          dec_op = op_auipc;
          dec_imm = imm_u;
        end
        opc_jal: begin
          dec_op = op_jal;
          dec_imm = imm_j;
        end
        opc_jalr: begin
          if (funct3 == 3'b000) begin
            dec_op = op_jalr;
          end
        end
        opc_branch: begin
          dec_imm = imm_b;
          case (funct3)
            3'b000: dec_op = op_beq;
            3'b001: dec_op = op_bne;
            3'b100: dec_op = op_blt;
            3'b101: dec_op = op_bge;
            3'b110: dec_op = op_bltu;
            3'b111: dec_op = op_bgeu;
            default: dec_op = op_illegal;
          endcase
        end
        opc_load: begin
          if (funct3 == 3'b010) begin
            dec_op = op_lw;
          end
        end
        opc_store: begin
          dec_imm = imm_s;
          if (funct3 == 3'b010) begin
            dec_op = op_sw;
          end
        end
        opc_op_imm: begin
          dec_use_imm = 1'b1;
          // funct7 only matters for the shifts
          casez ({funct7, funct3})
            10'b???????_000: dec_op = op_add;
            10'b???????_010: dec_op = op_slt;
            10'b???????_011: dec_op = op_sltu;
            10'b???????_100: dec_op = op_xor;
            10'b???????_110: dec_op = op_or;
            10'b???????_111: dec_op = op_and;
            10'b0000000_001: dec_op = op_sll;
            10'b0000000_101: dec_op = op_srl;
            10'b0100000_101: dec_op = op_sra;
            default: dec_op = op_illegal;
          endcase
        end
        opc_op: begin
          case ({funct7, funct3})
            10'b0000000_000: dec_op = op_add;
            10'b0100000_000: dec_op = op_sub;
            10'b0000000_001: dec_op = op_sll;
            10'b0000000_010: dec_op = op_slt;
            10'b0000000_011: dec_op = op_sltu;
            10'b0000000_100: dec_op = op_xor;
            10'b0000000_101: dec_op = op_srl;
            10'b0100000_101: dec_op = op_sra;
            10'b0000000_110: dec_op = op_or;
            10'b0000000_111: dec_op = op_and;
            default: dec_op = op_illegal;
          endcase
        end
        opc_system: begin
          // ecall or ebreak
          if (instr == 32'h0000_0073 || instr == 32'h0010_0073) begin
            dec_op = op_halt;
          end
        end
        default: dec_op = op_illegal;
      endcase
    end
  end

  assign instr_ready = !dec_valid;
  assign accept = instr_valid && instr_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (accept) begin
      dec_valid <= 1'b1;
    end else if (exec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op <= dec_op;
      use_imm <= dec_use_imm;
      immediate <= dec_imm;
      rd <= instr[11:7];
      rs1_value <= reg_rs1;
      rs2_value <= reg_rs2;
      pc <= instr_pc;
    end
  end

  // a stalled payload must not move under the executor
  payload_stable: assert property (@(posedge clk) disable iff (reset)
    dec_valid && !exec_ready |=> dec_valid && $stable(op) && $stable(use_imm) &&
      $stable(immediate) && $stable(rd) && $stable(rs1_value) && $stable(rs2_value) &&
      $stable(pc));

endmodule

// ==== execute/executor.sv ====
`timescale 1ns/1ps
module executor import rv_pkg::*; (
  input  var logic                     clk,
  input  var logic                     reset,
  // decoded instruction
  input  var logic                     dec_valid,
  output var logic                     exec_ready,
  input  var op_e                      op,
  input  var logic                     use_imm,
  input  var logic [xlen-1:0]          immediate,
  input  var logic [reg_addr_bits-1:0] rd,
  input  var logic [xlen-1:0]          rs1_value,
  input  var logic [xlen-1:0]          rs2_value,
  input  var logic [xlen-1:0]          pc,
  // data bus
  output var logic                     data_valid,
  input  var logic                     data_ready,
  output var logic [xlen-1:0]          data_addr,
  output var logic                     data_write,
  output var logic [xlen-1:0]          data_wdata,
  input  var logic                     data_rvalid,
  input  var logic [xlen-1:0]          data_rdata,
  // write-back and retire
  output var logic                     wb_enable,
  output var logic [reg_addr_bits-1:0] wb_rd,
  output var logic [xlen-1:0]          wb_value,
  output var logic                     retire,
  output var logic [xlen-1:0]          next_pc,
  output var logic                     halted,
  output var logic                     illegal_instr
);

  logic mem_busy;
  logic accept;
  logic [xlen-1:0] op_b, pc_plus4, base_sum, alu_result, target;
  logic [4:0] shamt;
  logic taken;
  logic writes_rd;

  assign exec_ready = !mem_busy && !halted;
  assign accept = dec_valid && exec_ready;

  assign op_b = use_imm ? immediate : rs2_value;
  assign shamt = op_b[4:0];
  assign pc_plus4 = pc + 32'd4;
  // jalr target and load/store address
  assign base_sum = rs1_value + immediate;

  always_comb begin
    case (op)
      op_lui: alu_result = immediate;
      op_auipc: alu_result = pc + immediate;
      op_jal, op_jalr: alu_result = pc_plus4;
      op_add: alu_result = rs1_value + op_b;
      op_sub: alu_result = rs1_value - op_b;
      op_sll: alu_result = rs1_value << shamt;
      op_slt: alu_result = {31'b0, $signed(rs1_value) < $signed(op_b)};
      op_sltu: alu_result = {31'b0, rs1_value < op_b};
      op_xor: alu_result = rs1_value ^ op_b;
      op_srl: alu_result = rs1_value >> shamt;
      op_sra: alu_result = $unsigned($signed(rs1_value) >>> shamt);
      op_or: alu_result = rs1_value | op_b;
      op_and: alu_result = rs1_value & op_b;
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    case (op)
      op_beq: taken = rs1_value == rs2_value;
      op_bne: taken = rs1_value != rs2_value;
      op_blt: taken = $signed(rs1_value) < $signed(rs2_value);
      op_bge: taken = $signed(rs1_value) >= $signed(rs2_value);
      op_bltu: taken = rs1_value < rs2_value;
      op_bgeu: taken = rs1_value >= rs2_value;
      default: taken = 1'b0;
    endcase
    case (op)
      op_jal: target = pc + immediate;
      op_jalr: target = {base_sum[xlen-1:1], 1'b0};
      default: target = taken ? pc + immediate : pc_plus4;
    endcase
  end

  assign writes_rd = !(op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_sw});

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_busy <= 1'b0;
      data_valid <= 1'b0;
      wb_enable <= 1'b0;
      retire <= 1'b0;
      halted <= 1'b0;
      illegal_instr <= 1'b0;
    end else begin
      wb_enable <= 1'b0;
      retire <= 1'b0;
      if (data_valid && data_ready) begin
        data_valid <= 1'b0;
      end
      if (accept) begin
        case (op)
          op_lw, op_sw: begin
            mem_busy <= 1'b1;
            data_valid <= 1'b1;
          end
          op_halt, op_illegal: begin
            halted <= 1'b1;
            illegal_instr <= op == op_illegal;
          end
          default: begin
            retire <= 1'b1;
            wb_enable <= writes_rd;
          end
        endcase
      end
      // the response ends a load or store
      if (mem_busy && data_rvalid) begin
        mem_busy <= 1'b0;
        retire <= 1'b1;
        wb_enable <= !data_write;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_addr <= base_sum;
      data_write <= op == op_sw;
      data_wdata <= rs2_value;
      wb_rd <= rd;
      wb_value <= alu_result;
      next_pc <= target;
    end else if (mem_busy && data_rvalid) begin
      wb_value <= data_rdata;
    end
  end

  // a halted core never hands the fetcher another pc
  no_retire_when_halted: assert property (@(posedge clk) disable iff (reset)
    !(retire && halted));

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
module rv_core import rv_pkg::*; (
  input  var logic            clk,
  input  var logic            reset,
  output var logic            mem_valid,
  input  var logic            mem_ready,
  output var logic [xlen-1:0] mem_addr,
  output var logic            mem_write,
  output var logic [xlen-1:0] mem_wdata,
  input  var logic            mem_rvalid,
  input  var logic [xlen-1:0] mem_rdata,
  output var logic            halted,
  output var logic            illegal_instr
);

  logic fetch_valid, fetch_ready, fetch_rvalid;
  logic [xlen-1:0] fetch_addr, fetch_rdata;
  logic data_valid, data_ready, data_write, data_rvalid;
  logic [xlen-1:0] data_addr, data_wdata, data_rdata;
  logic instr_valid, instr_ready;
  logic [xlen-1:0] instr, instr_pc;
  logic dec_valid, exec_ready, use_imm;
  op_e op;
  logic [xlen-1:0] immediate, rs1_value, rs2_value, pc;
  logic [reg_addr_bits-1:0] rs1, rs2, rd, wb_rd;
  logic [xlen-1:0] reg_rs1, reg_rs2, wb_value, next_pc;
  logic wb_enable, retire;

  fetcher u_fetcher (
    .clk, .reset, .retire, .next_pc,
    .fetch_valid, .fetch_ready, .fetch_addr, .fetch_rvalid, .fetch_rdata,
    .instr_valid, .instr_ready, .instr, .instr_pc
  );

  decoder u_decoder (
    .clk, .reset, .instr_valid, .instr_ready, .instr, .instr_pc,
    .rs1, .rs2, .reg_rs1, .reg_rs2,
    .dec_valid, .exec_ready, .op, .use_imm, .immediate, .rd, .rs1_value, .rs2_value, .pc
  );

  executor u_executor (
    .clk, .reset, .dec_valid, .exec_ready, .op, .use_imm, .immediate, .rd,
    .rs1_value, .rs2_value, .pc,
    .data_valid, .data_ready, .data_addr, .data_write, .data_wdata, .data_rvalid, .data_rdata,
    .wb_enable, .wb_rd, .wb_value, .retire, .next_pc, .halted, .illegal_instr
  );

  reg_file u_reg_file (
    .clk, .reset, .rs1, .rs2, .reg_rs1, .reg_rs2, .wb_enable, .wb_rd, .wb_value
  );

  mem_arbiter u_mem_arbiter (
    .clk, .reset,
    .fetch_valid, .fetch_ready, .fetch_addr, .fetch_rvalid, .fetch_rdata,
    .data_valid, .data_ready, .data_addr, .data_write, .data_wdata, .data_rvalid, .data_rdata,
    .mem_valid, .mem_ready, .mem_addr, .mem_write, .mem_wdata, .mem_rvalid, .mem_rdata
  );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ps
module tb_mem_model import rv_pkg::*; (
  input  var logic            clk,
  input  var logic            reset,
  input  var logic            mem_valid,
  output var logic            mem_ready,
  input  var logic [xlen-1:0] mem_addr,
  input  var logic            mem_write,
  input  var logic [xlen-1:0] mem_wdata,
  output var logic            mem_rvalid,
  output var logic [xlen-1:0] mem_rdata
);

  logic [xlen-1:0] mem [256];
  logic [31:0] lfsr_state = 32'h7999f701;
  logic ready_q = 1'b0;
  logic rvalid_q = 1'b0;
  logic [xlen-1:0] rdata_q = '0;
  logic busy = 1'b0;
  int acc_cnt = 0;
  int resp_cnt = 0;
  logic seen_reset, seen_valid, seen_accept, seen_write;
  logic [7:0] seen_idx, resp_idx;
  logic [xlen-1:0] seen_wdata;

  assign mem_ready = ready_q;
  assign mem_rvalid = rvalid_q;
  assign mem_rdata = rdata_q;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int next_delay(int bits);
    int d;
    d = 0;
    for (int i = 0; i < bits; i++) begin
      d = (d << 1) | int'(lfsr_bit());
    end
    return d;
  endfunction

  task automatic fill();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hbad0_0000 | (i << 2);
    end
  endtask

  task automatic load_word(int idx, logic [xlen-1:0] value);
    mem[idx] = value;
  endtask

  always @(posedge clk) begin
    seen_reset = reset;
    seen_valid = mem_valid;
    seen_accept = mem_valid && mem_ready;
    seen_write = mem_write;
    seen_idx = mem_addr[9:2];
    seen_wdata = mem_wdata;
    #1;
    rvalid_q = 1'b0;
    if (seen_reset) begin
      ready_q = 1'b0;
      busy = 1'b0;
      acc_cnt = next_delay(2);
    end else if (seen_accept) begin
      ready_q = 1'b0;
      busy = 1'b1;
      resp_idx = seen_idx;
      resp_cnt = next_delay(2);
      if (seen_write) begin
        mem[seen_idx] = seen_wdata;
      end
    end else if (busy) begin
      if (resp_cnt == 0) begin
        rvalid_q = 1'b1;
        rdata_q = mem[resp_idx];
        busy = 1'b0;
        acc_cnt = next_delay(2);
      end else begin
        resp_cnt--;
      end
    end else if (seen_valid && !ready_q) begin
      if (acc_cnt == 0) begin
        ready_q = 1'b1;
      end else begin
        acc_cnt--;
      end
    end
  end

endmodule

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
module tb_rv_core import rv_pkg::*; ();

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic mem_valid, mem_ready, mem_write, mem_rvalid, halted, illegal_instr;
  logic [xlen-1:0] mem_addr, mem_wdata, mem_rdata;

  // expected stores in program order
  logic [xlen-1:0] exp_addr [64];
  logic [xlen-1:0] exp_data [64];
  int n_exp;
  int prog_idx;
  int off;
  logic [xlen-1:0] wr_addr [$];
  logic [xlen-1:0] wr_data [$];
  int cycles = 0;
  int limit = 1000;
  logic stalled = 1'b0;
  logic held_write;
  logic [xlen-1:0] held_addr, held_wdata;

  rv_core u_dut (
    .clk, .reset, .mem_valid, .mem_ready, .mem_addr, .mem_write, .mem_wdata,
    .mem_rvalid, .mem_rdata, .halted, .illegal_instr
  );

  tb_mem_model u_mem (
    .clk, .reset, .mem_valid, .mem_ready, .mem_addr, .mem_write, .mem_wdata,
    .mem_rvalid, .mem_rdata
  );

  initial begin
    forever #4 clk = ~clk;
  end

  task automatic check_value(logic [31:0] actual, logic [31:0] expected, string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_i(logic [4:0] opc, logic [11:0] imm, int rs1,
                                        logic [2:0] f3, int rd);
    return {imm, 5'(rs1), f3, 5'(rd), opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opc_branch, 2'b11};
  endfunction

  function automatic logic [31:0] enc_u(logic [4:0] opc, logic [19:0] imm, int rd);
    return {imm, 5'(rd), opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), opc_jal, 2'b11};
  endfunction

  function automatic logic [31:0] enc_sw(logic [11:0] imm, int rs2, int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], opc_store, 2'b11};
  endfunction

  task automatic emit(logic [31:0] word);
    u_mem.load_word(prog_idx, word);
    prog_idx++;
  endtask

  task automatic expect_store(logic [xlen-1:0] addr, logic [xlen-1:0] value);
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = value;
    n_exp++;
  endtask

  // result area is based at x10 = 0x200
  task automatic store(int rs, logic [xlen-1:0] value);
    emit(enc_sw(12'(off), rs, 10));
    expect_store(32'h200 + off, value);
    off += 4;
  endtask

  // only reached when a branch or jump fails to skip it
  task automatic poison();
    emit(enc_sw(12'h100, 0, 10));
  endtask

  task automatic begin_run();
    reset = 1'b1;
    n_exp = 0;
    prog_idx = 0;
    off = 0;
    wr_addr.delete();
    wr_data.delete();
    u_mem.fill();
  endtask

  task automatic build_main();
    logic [xlen-1:0] pc_a;
    emit(enc_i(opc_op_imm, 12'h200, 0, 3'b000, 10));
    emit(enc_i(opc_op_imm, 12'd5, 0, 3'b000, 1));
    emit(enc_i(opc_op_imm, -12'sd12, 0, 3'b000, 2));
    emit(enc_r(7'h00, 2, 1, 3'b000, 3));
    store(3, 32'd5 + 32'hffff_fff4);
    emit(enc_r(7'h20, 2, 1, 3'b000, 3));
    store(3, 32'd17);
    emit(enc_r(7'h00, 2, 1, 3'b100, 3));
    store(3, 32'd5 ^ 32'hffff_fff4);
    emit(enc_r(7'h00, 2, 1, 3'b110, 3));
    store(3, 32'd5 | 32'hffff_fff4);
    emit(enc_r(7'h00, 2, 1, 3'b111, 3));
    store(3, 32'd5 & 32'hffff_fff4);
    emit(enc_r(7'h00, 1, 2, 3'b010, 3));
    store(3, 32'd1);
    emit(enc_r(7'h00, 1, 2, 3'b011, 3));
    store(3, 32'd0);
    emit(enc_r(7'h00, 1, 1, 3'b001, 3));
    store(3, 32'd5 << 5);
    emit(enc_r(7'h00, 1, 2, 3'b101, 3));
    store(3, 32'hffff_fff4 >> 5);
    emit(enc_r(7'h20, 1, 2, 3'b101, 3));
    store(3, 32'hffff_ffff);
    emit(enc_i(opc_op_imm, 12'hfff, 1, 3'b100, 3));
    store(3, 32'hffff_fffa);
    emit(enc_i(opc_op_imm, 12'd6, 1, 3'b010, 3));
    store(3, 32'd1);
    emit(enc_i(opc_op_imm, 12'd4, 1, 3'b001, 3));
    store(3, 32'd80);
    emit(enc_i(opc_op_imm, 12'h402, 2, 3'b101, 3));
    store(3, 32'hffff_fffd);
    emit(enc_u(opc_lui, 20'h12345, 3));
    store(3, 32'h1234_5000);
    pc_a = prog_idx * 4;
    emit(enc_u(opc_auipc, 20'h00001, 3));
    store(3, pc_a + 32'h1000);
    // branches, taken ones skip a poison store
    emit(enc_b(13'd8, 1, 1, 3'b000));
    poison();
    emit(enc_b(13'd8, 1, 1, 3'b001));
    store(1, 32'd5);
    emit(enc_b(13'd8, 1, 2, 3'b100));
    poison();
    emit(enc_b(13'd8, 1, 2, 3'b110));
    store(2, 32'hffff_fff4);
    emit(enc_b(13'd8, 2, 1, 3'b101));
    poison();
    emit(enc_b(13'd8, 1, 2, 3'b111));
    poison();
    pc_a = prog_idx * 4;
    emit(enc_j(21'd8, 4));
    poison();
    store(4, pc_a + 32'd4);
    pc_a = prog_idx * 4;
    emit(enc_u(opc_auipc, 20'h0, 5));
    emit(enc_i(opc_jalr, 12'd12, 5, 3'b000, 6));
    poison();
    store(6, pc_a + 32'd8);
    // store then load back the same word
    emit(enc_i(opc_op_imm, 12'h5a5, 0, 3'b000, 3));
    emit(enc_sw(12'h080, 3, 10));
    expect_store(32'h280, 32'h5a5);
    emit(enc_i(opc_load, 12'h080, 10, 3'b010, 7));
    store(7, 32'h5a5);
    emit(enc_i(opc_op_imm, 12'd99, 0, 3'b000, 0));
    store(0, 32'd0);
    emit(32'h0000_0073);
  endtask

  task automatic build_illegal();
    emit(enc_i(opc_op_imm, 12'h200, 0, 3'b000, 10));
    emit(enc_i(opc_op_imm, 12'd3, 0, 3'b000, 1));
    store(1, 32'd3);
    emit(32'hffff_ffff);
  endtask

  task automatic run_and_check(logic exp_illegal);
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    cycles = 0;
    limit = 200 * (n_exp + 1);
    while (!halted) begin
      @(posedge clk);
    end
    repeat (20) begin
      @(posedge clk);
      check_value(32'(mem_valid), 32'd0, "bus request after halt");
    end
    check_value(wr_addr.size(), n_exp, "number of stores");
    for (int i = 0; i < n_exp; i++) begin
      check_value(wr_addr[i], exp_addr[i], $sformatf("store %0d address", i));
      check_value(wr_data[i], exp_data[i], $sformatf("store %0d data", i));
    end
    check_value(32'(halted), 32'd1, "halted");
    check_value(32'(illegal_instr), 32'(exp_illegal), "illegal_instr");
    @(posedge clk);
    #1;
  endtask

  // write log and hold check for stalled requests
  always @(posedge clk) begin
    if (!reset) begin
      if (stalled) begin
        check_value(32'(mem_valid), 32'd1, "request dropped while stalled");
        check_value(mem_addr, held_addr, "stalled address");
        check_value(32'(mem_write), 32'(held_write), "stalled write flag");
        if (held_write) begin
          check_value(mem_wdata, held_wdata, "stalled write data");
        end
      end
      if (mem_valid && mem_ready && mem_write) begin
        wr_addr.push_back(mem_addr);
        wr_data.push_back(mem_wdata);
      end
      stalled <= mem_valid && !mem_ready;
      held_addr <= mem_addr;
      held_write <= mem_write;
      held_wdata <= mem_wdata;
    end else begin
      stalled <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycles++;
      if (cycles > limit) begin
        $display("timeout: the core never halted within %0d cycles", limit);
        $display("Test failures found");
        $fatal(1);
      end
    end
  end

  initial begin
    begin_run();
    build_main();
    run_and_check(1'b0);
    begin_run();
    build_illegal();
    run_and_check(1'b1);
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== compile.f ====
common/rv_pkg.sv
design/reg_file.sv
design/mem_arbiter.sv
fetch/fetcher.sv
decode/decoder.sv
execute/executor.sv
design/rv_core.sv
sim/tb_mem_model.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_core -f compile.f -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
